/* hw/mldsa_params_pkg.sv */
// ------------------------------------------------
// ML-DSA arithmetic parameters
// Modulus, coefficient and product widths, Barrett
// reduction constants and pipeline latencies
// ------------------------------------------------
`default_nettype none

package mldsa_params_pkg;

    // Coefficient width and prime modulus
    localparam int unsigned REG_SIZE = 23;
    localparam logic [REG_SIZE-1:0] MLDSA_Q = 23'd8380417;

    // Full product of two coefficients
    localparam int unsigned PROD_SIZE = 2 * REG_SIZE;

    // Barrett constants, m = floor(2^k / q) with k = 2 * REG_SIZE
    // m is one bit wider than a coefficient
    localparam int unsigned BARRETT_K = 46;
    localparam logic [REG_SIZE:0] BARRETT_M = 24'd8396807;

    // Pipeline latencies in clock cycles
    localparam int unsigned ADD_SUB_LAT = 1;
    localparam int unsigned MOD_MUL_LAT = 2;
    // Share products plus the combine stage
    localparam int unsigned MULT_LAT = MOD_MUL_LAT + 1;
    localparam int unsigned BFU_LAT = ADD_SUB_LAT + MULT_LAT;

endpackage

`default_nettype wire

/* hw/masked_ntt_pkg.sv */
// ------------------------------------------------
// Masked NTT types
// Share and masked coefficient structs, butterfly
// port bundles and modular add/sub helpers
// ------------------------------------------------
`default_nettype none

package masked_ntt_pkg;

    // One residue below q
    typedef logic [mldsa_params_pkg::REG_SIZE-1:0] coeff_t;

    // Two arithmetic shares, value is share0 + share1 mod q
    typedef struct packed {
        coeff_t share0;
        coeff_t share1;
    } masked_coeff_t;

    // Fresh randomness per cycle, every word below q
    typedef struct packed {
        coeff_t rnd0;
        coeff_t rnd1;
        coeff_t rnd2;
        coeff_t rnd3;
        coeff_t rnd4;
    } bfu_rnd_t;

    // Butterfly operands
    typedef struct packed {
        masked_coeff_t opu;
        masked_coeff_t opv;
        masked_coeff_t opw;
    } bfu_in_t;

    // Butterfly results
    typedef struct packed {
        masked_coeff_t u;
        masked_coeff_t v;
    } bfu_out_t;

    // Modular add of two residues
    function automatic coeff_t mod_add(input coeff_t a, input coeff_t b);
        logic [mldsa_params_pkg::REG_SIZE:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        // Sum below 2q, one subtraction is enough
        if (sum >= {1'b0, mldsa_params_pkg::MLDSA_Q}) begin
            return sum[mldsa_params_pkg::REG_SIZE-1:0] - mldsa_params_pkg::MLDSA_Q;
        end
        return sum[mldsa_params_pkg::REG_SIZE-1:0];
    endfunction

    // Modular subtract of two residues
    function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b);
        coeff_t diff;
        diff = a - b;
        // Borrow wraps back into range by adding q
        if (a < b) begin
            diff = diff + mldsa_params_pkg::MLDSA_Q;
        end
        return diff;
    endfunction

endpackage

`default_nettype wire

/* hw/masked_mod_mul.sv */
// ------------------------------------------------
// Single share modular multiplier
// Registered 46-bit product followed by a
// registered Barrett reduction modulo q
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_mod_mul (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     zeroize_i,
    input  wire masked_ntt_pkg::coeff_t a_i,
    input  wire masked_ntt_pkg::coeff_t b_i,
    output masked_ntt_pkg::coeff_t  res_o
);

    import mldsa_params_pkg::*;
    import masked_ntt_pkg::*;

    // Stage 1 product
    logic [PROD_SIZE-1:0] prod_d;
    logic [PROD_SIZE-1:0] prod_q;

    // Stage 2 reduction
    logic [PROD_SIZE+REG_SIZE:0] est_full;
    logic [REG_SIZE:0]           quot;
    logic [REG_SIZE:0]           tq_lo;
    logic [REG_SIZE:0]           rem;
    coeff_t                      res_d;

    // Full width product, both operands below q
    assign prod_d = a_i * b_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod_d;
        end
    end

    always_comb begin
        // Quotient estimate, x * m >> k
        est_full = prod_q * BARRETT_M;
        quot     = est_full[BARRETT_K +: REG_SIZE+1];
        // Estimate is low by at most one, so remainder is below 2q
        // Low bits of x - t*q are all that is needed
        tq_lo    = quot * MLDSA_Q;
        rem      = prod_q[REG_SIZE:0] - tq_lo;
        // Final conditional subtraction
        if (rem >= {1'b0, MLDSA_Q}) begin
            res_d = rem[REG_SIZE-1:0] - MLDSA_Q;
        end else begin
            res_d = rem[REG_SIZE-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* hw/masked_bfu_add_sub.sv */
// ------------------------------------------------
// Masked modular adder/subtractor
// Share-wise u +/- v with a random refresh added
// to share0 and taken from share1, one cycle
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_bfu_add_sub (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            zeroize_i,
    input  wire                            sub_i,
    input  wire masked_ntt_pkg::masked_coeff_t u_i,
    input  wire masked_ntt_pkg::masked_coeff_t v_i,
    input  wire masked_ntt_pkg::coeff_t    rnd_i,
    output masked_ntt_pkg::masked_coeff_t  res_o
);

    import masked_ntt_pkg::*;

    // Per-share add or subtract before refresh
    coeff_t        op0;
    coeff_t        op1;
    masked_coeff_t res_d;

    always_comb begin
        // Shares never mix here
        if (sub_i) begin
            op0 = mod_sub(u_i.share0, v_i.share0);
            op1 = mod_sub(u_i.share1, v_i.share1);
        end else begin
            op0 = mod_add(u_i.share0, v_i.share0);
            op1 = mod_add(u_i.share1, v_i.share1);
        end
        // Refresh, +r on share0 and -r on share1 keeps the sum
        res_d.share0 = mod_add(op0, rnd_i);
        res_d.share1 = mod_sub(op1, rnd_i);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* hw/masked_bfu_mult.sv */
// ------------------------------------------------
// Masked modular multiplier
// Four share cross products, then a combine stage
// that masks the cross terms and refreshes the
// output shares, three cycles in total
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_bfu_mult (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            zeroize_i,
    input  wire masked_ntt_pkg::masked_coeff_t u_i,
    input  wire masked_ntt_pkg::masked_coeff_t w_i,
    input  wire masked_ntt_pkg::coeff_t    rnd_mask_i,
    input  wire masked_ntt_pkg::coeff_t    rnd_ref_i,
    output masked_ntt_pkg::masked_coeff_t  res_o
);

    import masked_ntt_pkg::*;

    // Share products, valid two cycles after the operands
    coeff_t        p_u0w0;
    coeff_t        p_u0w1;
    coeff_t        p_u1w0;
    coeff_t        p_u1w1;

    // Combine stage intermediates
    coeff_t        part0;
    coeff_t        part1;
    masked_coeff_t res_d;

    // Same share pair
    masked_mod_mul mul_u0w0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (u_i.share0),
        .b_i       (w_i.share0),
        .res_o     (p_u0w0)
    );

    // Cross term, lands in share0
    masked_mod_mul mul_u0w1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (u_i.share0),
        .b_i       (w_i.share1),
        .res_o     (p_u0w1)
    );

    // Cross term, lands in share1
    masked_mod_mul mul_u1w0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (u_i.share1),
        .b_i       (w_i.share0),
        .res_o     (p_u1w0)
    );

    masked_mod_mul mul_u1w1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (u_i.share1),
        .b_i       (w_i.share1),
        .res_o     (p_u1w1)
    );

    always_comb begin
        // Mask goes in first so no cross term is added unmasked
        part0 = mod_add(mod_add(p_u0w0, rnd_mask_i), p_u0w1);
        part1 = mod_add(mod_sub(p_u1w1, rnd_mask_i), p_u1w0);
        // Output refresh
        res_d.share0 = mod_add(part0, rnd_ref_i);
        res_d.share1 = mod_sub(part1, rnd_ref_i);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* hw/masked_gs_butterfly.sv */
// ------------------------------------------------
// Masked Gentleman-Sande butterfly
// u = opu + opv and v = (opu - opv) * opw, all in
// two shares, fixed latency with a valid pipeline
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_gs_butterfly (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       zeroize_i,
    input  wire                       valid_i,
    input  wire masked_ntt_pkg::bfu_in_t  in_i,
    input  wire masked_ntt_pkg::bfu_rnd_t rnd_i,
    output logic                      valid_o,
    output masked_ntt_pkg::bfu_out_t  out_o
);

    import mldsa_params_pkg::*;
    import masked_ntt_pkg::*;

    // Unit results
    masked_coeff_t sum_res;
    masked_coeff_t diff_res;
    masked_coeff_t mul_res;

    // Delay lines
    masked_coeff_t [ADD_SUB_LAT-1:0] w_dly;
    masked_coeff_t [MULT_LAT-1:0]    sum_dly;
    logic [BFU_LAT-1:0]              valid_sr;

    // u + v
    masked_bfu_add_sub sum_unit (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b0),
        .u_i       (in_i.opu),
        .v_i       (in_i.opv),
        .rnd_i     (rnd_i.rnd0),
        .res_o     (sum_res)
    );

    // u - v, separate refresh word
    masked_bfu_add_sub diff_unit (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b1),
        .u_i       (in_i.opu),
        .v_i       (in_i.opv),
        .rnd_i     (rnd_i.rnd1),
        .res_o     (diff_res)
    );

    // Twiddle times difference, rnd4 stays unused in this scheme
    masked_bfu_mult mult_unit (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .u_i        (diff_res),
        .w_i        (w_dly[ADD_SUB_LAT-1]),
        .rnd_mask_i (rnd_i.rnd2),
        .rnd_ref_i  (rnd_i.rnd3),
        .res_o      (mul_res)
    );

    // Twiddle waits for the difference, sum waits for the product
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w_dly    <= '0;
            sum_dly  <= '0;
            valid_sr <= '0;
        end else if (zeroize_i) begin
            w_dly    <= '0;
            sum_dly  <= '0;
            valid_sr <= '0;
        end else begin
            w_dly[0] <= in_i.opw;
            for (int i = 1; i < ADD_SUB_LAT; i++) begin
                w_dly[i] <= w_dly[i-1];
            end
            sum_dly[0] <= sum_res;
            for (int i = 1; i < MULT_LAT; i++) begin
                sum_dly[i] <= sum_dly[i-1];
            end
            valid_sr <= {valid_sr[BFU_LAT-2:0], valid_i};
        end
    end

    // Outputs straight from registers
    assign valid_o = valid_sr[BFU_LAT-1];
    assign out_o.u = sum_dly[MULT_LAT-1];
    assign out_o.v = mul_res;

endmodule

`default_nettype wire

/* hw/masked_gs_bfu_top.sv */
// ------------------------------------------------
// Masked GS butterfly top level
// Brings the operand, randomness and valid ports
// out to the butterfly core
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_gs_bfu_top (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       zeroize_i,
    input  wire                       valid_i,
    input  wire masked_ntt_pkg::bfu_in_t  bfu_in_i,
    input  wire masked_ntt_pkg::bfu_rnd_t rnd_i,
    output logic                      valid_o,
    output masked_ntt_pkg::bfu_out_t  bfu_out_o
);

    // Randomness sampled every cycle, valid only qualifies operands
    masked_gs_butterfly u_butterfly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (valid_i),
        .in_i      (bfu_in_i),
        .rnd_i     (rnd_i),
        .valid_o   (valid_o),
        .out_o     (bfu_out_o)
    );

endmodule

`default_nettype wire

/* tb/masked_gs_bfu_tb.sv */
// ------------------------------------------------
// Masked GS butterfly testbench
// Drives shared operands and randomness, unmasks
// the results and checks them with assertions
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module masked_gs_bfu_tb;

    import mldsa_params_pkg::*;
    import masked_ntt_pkg::*;

    localparam longint unsigned QL = MLDSA_Q;
    localparam int STREAM_LEN = 200;
    localparam int GAP_LEN    = 40;
    localparam int ZERO_LEN   = 10;
    localparam int N_ISO      = 12;
    localparam int ISO_CYC    = BFU_LAT + 4;
    // Reset with idle tail, isolated items, stream, zeroize run
    localparam int STIM_CYCLES = 10 + N_ISO * ISO_CYC + STREAM_LEN + GAP_LEN + ISO_CYC
                               + 2 * ZERO_LEN + 2 + ISO_CYC + 8;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + BFU_LAT + 50;

    // Expected result with the checker cycle it was accepted in
    typedef struct packed {
        coeff_t      u;
        coeff_t      v;
        logic [31:0] stamp;
    } exp_t;

    logic     clk;
    logic     reset_n;
    logic     zeroize_i;
    logic     valid_i;
    bfu_in_t  bfu_in_i;
    bfu_rnd_t rnd_i;
    logic     valid_o;
    bfu_out_t bfu_out_o;

    int          seed;
    int          err_cnt;
    int          test_cnt;
    int          fail_tests;
    int          cycle_cnt;
    string       cur_test;
    exp_t        exp_q[$];
    coeff_t      s0_log[$];
    logic [31:0] mon_cycle;
    logic        chk_en;
    logic        orphan;
    logic        quiet_chk;
    logic        refresh_chk;
    coeff_t      chk_exp_u;
    coeff_t      chk_exp_v;
    coeff_t      chk_act_u;
    coeff_t      chk_act_v;
    logic [31:0] chk_lat;
    coeff_t      ref_s0_a;
    coeff_t      ref_s0_b;

    masked_gs_bfu_top dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (valid_i),
        .bfu_in_i  (bfu_in_i),
        .rnd_i     (rnd_i),
        .valid_o   (valid_o),
        .bfu_out_o (bfu_out_o)
    );

    always #5 clk = ~clk;

    function automatic coeff_t rand_coeff();
        return coeff_t'({$random(seed)} % QL);
    endfunction

    function automatic bfu_rnd_t rand_rnd();
        bfu_rnd_t r;
        r.rnd0 = rand_coeff();
        r.rnd1 = rand_coeff();
        r.rnd2 = rand_coeff();
        r.rnd3 = rand_coeff();
        r.rnd4 = rand_coeff();
        return r;
    endfunction

    // Random share0, share1 closes the gap to the value
    function automatic masked_coeff_t split(input longint unsigned val);
        masked_coeff_t mc;
        mc.share0 = rand_coeff();
        mc.share1 = coeff_t'((val + QL - mc.share0) % QL);
        return mc;
    endfunction

    function automatic bfu_in_t make_in(input longint unsigned a, input longint unsigned b,
                                        input longint unsigned w);
        bfu_in_t d;
        d.opu = split(a);
        d.opv = split(b);
        d.opw = split(w);
        return d;
    endfunction

    function automatic longint unsigned unmask(input masked_coeff_t mc);
        longint unsigned s0;
        longint unsigned s1;
        s0 = mc.share0;
        s1 = mc.share1;
        return (s0 + s1) % QL;
    endfunction

    function automatic longint unsigned expect_v(input bfu_in_t d);
        longint unsigned diff;
        diff = (unmask(d.opu) + QL - unmask(d.opv)) % QL;
        return (diff * unmask(d.opw)) % QL;
    endfunction

    // Scoreboard, pops on valid_o and pushes what the DUT accepts
    always @(posedge clk or negedge reset_n) begin
        exp_t head;
        if (!reset_n) begin
            mon_cycle <= '0;
            chk_en    <= 1'b0;
            orphan    <= 1'b0;
            exp_q.delete();
        end else begin
            mon_cycle <= mon_cycle + 1;
            chk_en    <= 1'b0;
            orphan    <= 1'b0;
            if (valid_o) begin
                if (exp_q.size() == 0) begin
                    orphan <= 1'b1;
                end else begin
                    head = exp_q.pop_front();
                    chk_en    <= 1'b1;
                    chk_exp_u <= head.u;
                    chk_exp_v <= head.v;
                    chk_act_u <= coeff_t'(unmask(bfu_out_o.u));
                    chk_act_v <= coeff_t'(unmask(bfu_out_o.v));
                    chk_lat   <= mon_cycle - head.stamp;
                    s0_log.push_back(bfu_out_o.u.share0);
                end
            end
            // Zeroize wins over a new operand set
            if (zeroize_i) begin
                exp_q.delete();
            end else if (valid_i) begin
                head.u     = coeff_t'((unmask(bfu_in_i.opu) + unmask(bfu_in_i.opv)) % QL);
                head.v     = coeff_t'(expect_v(bfu_in_i));
                head.stamp = mon_cycle;
                exp_q.push_back(head);
            end
        end
    end

    quiet_check: assert property (@(posedge clk) quiet_chk |-> (!valid_o && bfu_out_o == '0))
    else begin
        err_cnt++;
        $display("%s: outputs not idle before the first result", cur_test);
    end

    sum_check: assert property (@(posedge clk) disable iff (!reset_n)
        chk_en |-> chk_act_u == chk_exp_u)
    else begin
        err_cnt++;
        $display("FAILED %s u: expected %0d, actual %0d", cur_test,
                 $sampled(chk_exp_u), $sampled(chk_act_u));
    end

    product_check: assert property (@(posedge clk) disable iff (!reset_n)
        chk_en |-> chk_act_v == chk_exp_v)
    else begin
        err_cnt++;
        $display("FAILED %s v: expected %0d, actual %0d", cur_test,
                 $sampled(chk_exp_v), $sampled(chk_act_v));
    end

    latency_check: assert property (@(posedge clk) disable iff (!reset_n)
        chk_en |-> chk_lat == BFU_LAT)
    else begin
        err_cnt++;
        $display("FAILED %s latency: expected %0d, actual %0d", cur_test,
                 BFU_LAT, $sampled(chk_lat));
    end

    orphan_check: assert property (@(posedge clk) disable iff (!reset_n) !orphan)
    else begin
        err_cnt++;
        $display("%s: valid_o high with no input pending", cur_test);
    end

    zeroize_check: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (!valid_o && bfu_out_o == '0))
    else begin
        err_cnt++;
        $display("%s: outputs not cleared one cycle after zeroize", cur_test);
    end

    refresh_check: assert property (@(posedge clk) refresh_chk |-> ref_s0_a != ref_s0_b)
    else begin
        err_cnt++;
        $display("%s: output share0 repeated under fresh randomness", cur_test);
    end

    task automatic step(input logic vld, input bfu_in_t din, input bfu_rnd_t rnd);
        @(posedge clk);
        valid_i  <= vld;
        bfu_in_i <= din;
        rnd_i    <= rnd;
    endtask

    // Waits until every accepted item has been checked
    task automatic drain();
        do begin
            @(negedge clk);
        end while (exp_q.size() != 0);
        repeat (2) @(posedge clk);
    endtask

    task automatic send_single(input longint unsigned a, input longint unsigned b,
                               input longint unsigned w);
        step(1'b1, make_in(a, b, w), rand_rnd());
        step(1'b0, '0, rand_rnd());
        drain();
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = err_cnt - errs_before;
        test_cnt++;
        if (errs != 0) begin
            fail_tests++;
        end
        $display("test %-10s %s (%0d errors)", name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int       e0;
        bfu_in_t  din;
        bfu_rnd_t ra;
        bfu_rnd_t rb;
        seed        = 32'h3ce8_5201;
        err_cnt     = 0;
        test_cnt    = 0;
        fail_tests  = 0;
        clk         = 1'b0;
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        valid_i     = 1'b0;
        bfu_in_i    = '0;
        rnd_i       = '0;
        quiet_chk   = 1'b1;
        refresh_chk = 1'b0;

        // Zero randomness keeps the idle outputs at zero
        cur_test = "reset";
        e0 = err_cnt;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        repeat (6) step(1'b0, '0, '0);
        quiet_chk <= 1'b0;
        report_test(cur_test, e0);

        cur_test = "sum";
        e0 = err_cnt;
        send_single(QL - 1, 1, rand_coeff());
        send_single(QL - 1, QL - 1, rand_coeff());
        send_single(0, 0, rand_coeff());
        send_single(QL - 2, 5, rand_coeff());
        send_single(4096, 8000000, rand_coeff());
        report_test(cur_test, e0);

        cur_test = "product";
        e0 = err_cnt;
        send_single(3, 7, QL - 1);
        send_single(5, QL - 3, 2);
        send_single(0, 12345, rand_coeff());
        send_single(QL - 1, 0, QL - 1);
        send_single(rand_coeff(), rand_coeff(), 0);
        report_test(cur_test, e0);

        cur_test = "stream";
        e0 = err_cnt;
        repeat (STREAM_LEN) step(1'b1, make_in(rand_coeff(), rand_coeff(), rand_coeff()),
                                 rand_rnd());
        // Random idle cycles between items
        repeat (GAP_LEN) step(1'($random(seed) & 1),
                              make_in(rand_coeff(), rand_coeff(), rand_coeff()), rand_rnd());
        step(1'b0, '0, rand_rnd());
        drain();
        report_test(cur_test, e0);

        cur_test = "refresh";
        e0 = err_cnt;
        s0_log.delete();
        din = make_in(rand_coeff(), rand_coeff(), rand_coeff());
        ra = rand_rnd();
        rb = rand_rnd();
        rb.rnd0 = coeff_t'((longint'(ra.rnd0) + 1) % QL);
        step(1'b1, din, ra);
        step(1'b1, din, rb);
        step(1'b0, '0, rand_rnd());
        drain();
        if (s0_log.size() != 2) begin
            err_cnt++;
            $display("%s: expected two results, got %0d", cur_test, s0_log.size());
        end else begin
            ref_s0_a    <= s0_log[0];
            ref_s0_b    <= s0_log[1];
            refresh_chk <= 1'b1;
            @(posedge clk);
            refresh_chk <= 1'b0;
            @(posedge clk);
        end
        report_test(cur_test, e0);

        cur_test = "zeroize";
        e0 = err_cnt;
        repeat (ZERO_LEN) step(1'b1, make_in(rand_coeff(), rand_coeff(), rand_coeff()),
                               rand_rnd());
        // Item beside zeroize is dropped along with those in flight
        step(1'b1, make_in(rand_coeff(), rand_coeff(), rand_coeff()), rand_rnd());
        zeroize_i <= 1'b1;
        step(1'b0, '0, rand_rnd());
        zeroize_i <= 1'b0;
        repeat (ZERO_LEN) step(1'b1, make_in(rand_coeff(), rand_coeff(), rand_coeff()),
                               rand_rnd());
        step(1'b0, '0, rand_rnd());
        drain();
        report_test(cur_test, e0);

        $display("tests run: %0d, tests failed: %0d, errors: %0d", test_cnt, fail_tests,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/mldsa_params_pkg.sv
hw/masked_ntt_pkg.sv
hw/masked_mod_mul.sv
hw/masked_bfu_add_sub.sv
hw/masked_bfu_mult.sv
hw/masked_gs_butterfly.sv
hw/masked_gs_bfu_top.sv
tb/masked_gs_bfu_tb.sv

/* Bender.yml */
package:
  name: masked_gs_bfu

sources:
  - hw/mldsa_params_pkg.sv
  - hw/masked_ntt_pkg.sv
  - hw/masked_mod_mul.sv
  - hw/masked_bfu_add_sub.sv
  - hw/masked_bfu_mult.sv
  - hw/masked_gs_butterfly.sv
  - hw/masked_gs_bfu_top.sv
  - target: test
    files:
      - tb/masked_gs_bfu_tb.sv
